// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_board_io_subsystem
FILELIST  = src.f
LOG       = sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== board_io_pkg.sv ====
package board_io_pkg;

    localparam int GPIO_COUNT = 16;

    typedef logic [GPIO_COUNT-1:0] gpio_t;

    // Timer register indices, taken from address bits 3:2.
    localparam logic [1:0] TIMER_REG_COUNT   = 2'd0;  // Read counter, write clears it.
    localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
    localparam logic [1:0] TIMER_REG_CONTROL = 2'd2;

    localparam int TIMER_ENABLE_BIT = 0;  // Enable bit in the control register.

    localparam int IRQ_VECTOR_WIDTH = 5;

    typedef logic [IRQ_VECTOR_WIDTH-1:0] irq_vector_t;

    // The timer sits just above the 16 input lines.
    localparam irq_vector_t TIMER_VECTOR  = 5'd16;
    localparam irq_vector_t NO_IRQ_VECTOR = 5'd0;

endpackage

// ==== board_io_stim.txt ====
# op addr data expected, all hex. S store, L load, B store and load together, K load at least
# G set gpio_i, O expect gpio_o, V wait {timer_irq,irq}=data then expect vector, A ack, W wait
S 00000000 11111111 0
S 00000004 a5a5a5a5 0
S 00000400 0badf00d 0
S 00000ffc deadbeef 0
L 00000000 0 11111111
L 00000004 0 a5a5a5a5
L 00000400 0 0badf00d
L 00000ffc 0 deadbeef
B 00000004 12345678 a5a5a5a5
L 00000004 0 12345678
L 00000000 0 11111111
O 0 0 0000
S 00001014 1 0
O 0 0 0020
L 00001014 0 1
L 00001010 0 0
S 00001030 1 0
S 00001014 0 0
O 0 0 1000
G 0 0208 0
V 0 1 9
L 000010a4 0 1
L 00001090 0 0
A 0 0 0
V 0 0 0
G 0 1208 0
S 00001104 5 0
S 00001108 1 0
V 0 3 10
K 00001100 0 5
A 0 0 0
V 0 0 0
S 00001108 0 0
W 0 4 0

// ==== board_io_subsystem.sv ====
`timescale 1ns/10ps

module board_io_subsystem (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  board_io_pkg::gpio_t             gpio_i,
    output board_io_pkg::gpio_t             gpio_o,
    input  logic                            store_req_i,
    input  board_memory_map_pkg::bus_word_t store_addr_i,
    input  board_memory_map_pkg::bus_word_t store_data_i,
    output logic                            store_done_o,
    input  logic                            load_req_i,
    input  board_memory_map_pkg::bus_word_t load_addr_i,
    output board_memory_map_pkg::bus_word_t load_data_o,
    output logic                            load_valid_o,
    input  logic                            irq_ack_i,
    output logic                            irq_o,
    output logic                            timer_irq_o,
    output board_io_pkg::irq_vector_t       irq_vector_o
);
    import board_memory_map_pkg::*;
    import board_io_pkg::*;

    logic       sys_rst_n;
    logic       mem_store, mem_load, mem_done, mem_valid;
    bus_word_t  mem_store_addr, mem_load_addr, mem_wdata, mem_rdata;
    gpio_t      gpio_write, gpio_in_sync, gpio_rise;
    logic       gpio_wbit;
    logic       timer_write, timer_level;
    logic [1:0] timer_waddr, timer_raddr;
    bus_word_t  timer_wdata, timer_rdata;

    io_bus_controller i_io_bus_controller (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .store_req_i      (store_req_i),
        .store_addr_i     (store_addr_i),
        .store_data_i     (store_data_i),
        .load_req_i       (load_req_i),
        .load_addr_i      (load_addr_i),
        .mem_done_i       (mem_done),
        .mem_valid_i      (mem_valid),
        .mem_rdata_i      (mem_rdata),
        .gpio_in_sync_i   (gpio_in_sync),
        .gpio_out_i       (gpio_o),
        .timer_rdata_i    (timer_rdata),
        .sys_rst_n_o      (sys_rst_n),
        .store_done_o     (store_done_o),
        .load_valid_o     (load_valid_o),
        .load_data_o      (load_data_o),
        .mem_store_o      (mem_store),
        .mem_load_o       (mem_load),
        .mem_store_addr_o (mem_store_addr),
        .mem_load_addr_o  (mem_load_addr),
        .mem_wdata_o      (mem_wdata),
        .gpio_write_o     (gpio_write),
        .gpio_wbit_o      (gpio_wbit),
        .timer_write_o    (timer_write),
        .timer_waddr_o    (timer_waddr),
        .timer_raddr_o    (timer_raddr),
        .timer_wdata_o    (timer_wdata)
    );

    gpio_bank i_gpio_bank (
        .clk_i          (clk_i),
        .rst_n_i        (sys_rst_n),
        .gpio_i         (gpio_i),
        .gpio_write_i   (gpio_write),
        .gpio_wbit_i    (gpio_wbit),
        .gpio_o         (gpio_o),
        .gpio_in_sync_o (gpio_in_sync),
        .gpio_rise_o    (gpio_rise)
    );

    mmio_timer i_mmio_timer (
        .clk_i         (clk_i),
        .rst_n_i       (sys_rst_n),
        .write_i       (timer_write),
        .write_addr_i  (timer_waddr),
        .write_data_i  (timer_wdata),
        .read_addr_i   (timer_raddr),
        .read_data_o   (timer_rdata),
        .timer_level_o (timer_level)
    );

    interrupt_controller i_interrupt_controller (
        .clk_i         (clk_i),
        .rst_n_i       (sys_rst_n),
        .gpio_rise_i   (gpio_rise),
        .timer_level_i (timer_level),
        .irq_ack_i     (irq_ack_i),
        .irq_o         (irq_o),
        .timer_irq_o   (timer_irq_o),
        .irq_vector_o  (irq_vector_o)
    );

    data_memory i_data_memory (
        .clk_i        (clk_i),
        .rst_n_i      (sys_rst_n),
        .store_i      (mem_store),
        .store_addr_i (mem_store_addr),
        .store_data_i (mem_wdata),
        .load_i       (mem_load),
        .load_addr_i  (mem_load_addr),
        .store_done_o (mem_done),
        .load_valid_o (mem_valid),
        .load_data_o  (mem_rdata)
    );

endmodule

// ==== board_memory_map_pkg.sv ====
package board_memory_map_pkg;

    typedef logic [31:0] bus_word_t;

    // Data memory window, 4 KiB of words.
    localparam bus_word_t MEM_START = 32'h0000_0000;
    localparam bus_word_t MEM_END   = 32'h0000_0FFF;
    localparam int        MEM_WORDS = 1024;

    // Peripheral window.
    localparam bus_word_t IO_START = 32'h0000_1000;
    localparam bus_word_t IO_END   = 32'h0000_11FF;

    // Bits 5:2 select an output or input bit, or a timer register in bits 3:2.
    typedef union packed {
        logic [3:0] gpio_index;
        struct packed {
            logic [1:0] reserved;
            logic [1:0] timer_reg;
        } timer_view;
    } io_reg_sel_t;

    typedef union packed {
        struct packed {
            logic [19:0] upper;
            logic [9:0]  word_index;
            logic [1:0]  byte_offset;
        } mem_view;
        struct packed {
            logic [22:0] region;     // Bits 31:9.
            logic        timer_sel;  // Bit 8.
            logic        input_sel;  // Bit 7, input view when set.
            logic        reserved;
            io_reg_sel_t reg_sel;    // Bits 5:2.
            logic [1:0]  byte_offset;
        } io_view;
    } bus_address_t;

endpackage

// ==== data_memory.sv ====
`timescale 1ns/10ps

module data_memory (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            store_i,
    input  board_memory_map_pkg::bus_word_t store_addr_i,
    input  board_memory_map_pkg::bus_word_t store_data_i,
    input  logic                            load_i,
    input  board_memory_map_pkg::bus_word_t load_addr_i,
    output logic                            store_done_o,
    output logic                            load_valid_o,
    output board_memory_map_pkg::bus_word_t load_data_o
);
    import board_memory_map_pkg::*;

    bus_word_t    mem_q [MEM_WORDS];
    bus_address_t st_view, ld_view;

    assign st_view = store_addr_i;
    assign ld_view = load_addr_i;

    // Word array and registered read port.
    always_ff @(posedge clk_i) begin
        if (store_i) begin
            mem_q[st_view.mem_view.word_index] <= store_data_i;
        end
        if (load_i) begin
            load_data_o <= mem_q[ld_view.mem_view.word_index];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            store_done_o <= 1'b0;
            load_valid_o <= 1'b0;
        end else begin
            store_done_o <= store_i;  // One cycle after the strobe.
            load_valid_o <= load_i;
        end
    end

endmodule

// ==== gpio_bank.sv ====
`timescale 1ns/10ps

module gpio_bank (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  board_io_pkg::gpio_t gpio_i,
    input  board_io_pkg::gpio_t gpio_write_i,
    input  logic                gpio_wbit_i,
    output board_io_pkg::gpio_t gpio_o,
    output board_io_pkg::gpio_t gpio_in_sync_o,
    output board_io_pkg::gpio_t gpio_rise_o
);
    import board_io_pkg::*;

    gpio_t sync_meta_q;  // First stage, may go metastable.
    gpio_t sync_q;
    gpio_t prev_q;
    gpio_t out_q;

    // Input path: two synchronizer stages and one history stage.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
            prev_q      <= '0;
        end else begin
            sync_meta_q <= gpio_i;
            sync_q      <= sync_meta_q;
            prev_q      <= sync_q;
        end
    end

    assign gpio_in_sync_o = sync_q;
    assign gpio_rise_o    = sync_q & ~prev_q;  // One-cycle pulse per rising edge.

    // Output bits, each loaded only by its own strobe.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_COUNT; i++) begin
                if (gpio_write_i[i]) begin
                    out_q[i] <= gpio_wbit_i;
                end
            end
        end
    end

    assign gpio_o = out_q;

endmodule

// ==== interrupt_controller.sv ====
`timescale 1ns/10ps

module interrupt_controller (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  board_io_pkg::gpio_t       gpio_rise_i,
    input  logic                      timer_level_i,
    input  logic                      irq_ack_i,
    output logic                      irq_o,
    output logic                      timer_irq_o,
    output board_io_pkg::irq_vector_t irq_vector_o
);
    import board_io_pkg::*;

    gpio_t pending_q;
    logic  timer_level_q, timer_pending_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q       <= '0;
            timer_level_q   <= 1'b0;
            timer_pending_q <= 1'b0;
        end else begin
            timer_level_q <= timer_level_i;
            if (irq_ack_i) begin
                pending_q       <= '0;  // Edges in this cycle are dropped.
                timer_pending_q <= 1'b0;
            end else begin
                pending_q <= pending_q | gpio_rise_i;
                if (timer_level_i && !timer_level_q) begin
                    timer_pending_q <= 1'b1;
                end
            end
        end
    end

    assign irq_o       = |pending_q;
    assign timer_irq_o = timer_pending_q;

    // Timer first, then the highest pending input.
    always_comb begin
        irq_vector_o = NO_IRQ_VECTOR;
        if (timer_pending_q) begin
            irq_vector_o = TIMER_VECTOR;
        end else begin
            for (int i = 0; i < GPIO_COUNT; i++) begin
                if (pending_q[i]) begin
                    irq_vector_o = irq_vector_t'(i);
                end
            end
        end
    end

endmodule

// ==== io_bus_controller.sv ====
`timescale 1ns/10ps

module io_bus_controller (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           store_req_i,
    input  board_memory_map_pkg::bus_word_t store_addr_i,
    input  board_memory_map_pkg::bus_word_t store_data_i,
    input  logic                           load_req_i,
    input  board_memory_map_pkg::bus_word_t load_addr_i,
    input  logic                           mem_done_i,
    input  logic                           mem_valid_i,
    input  board_memory_map_pkg::bus_word_t mem_rdata_i,
    input  board_io_pkg::gpio_t            gpio_in_sync_i,
    input  board_io_pkg::gpio_t            gpio_out_i,
    input  board_memory_map_pkg::bus_word_t timer_rdata_i,
    output logic                           sys_rst_n_o,
    output logic                           store_done_o,
    output logic                           load_valid_o,
    output board_memory_map_pkg::bus_word_t load_data_o,
    output logic                           mem_store_o,
    output logic                           mem_load_o,
    output board_memory_map_pkg::bus_word_t mem_store_addr_o,
    output board_memory_map_pkg::bus_word_t mem_load_addr_o,
    output board_memory_map_pkg::bus_word_t mem_wdata_o,
    output board_io_pkg::gpio_t            gpio_write_o,
    output logic                           gpio_wbit_o,
    output logic                           timer_write_o,
    output logic [1:0]                     timer_waddr_o,
    output logic [1:0]                     timer_raddr_o,
    output board_memory_map_pkg::bus_word_t timer_wdata_o
);
    import board_memory_map_pkg::*;
    import board_io_pkg::*;

    logic         rst_sync_q, sys_rst_n;
    logic         wait_store_q;  // Arbiter state: set means wait_store, clear means idle.
    logic         hold_store, st_issue;
    bus_word_t    held_addr_q, held_data_q;
    bus_word_t    st_addr, st_data;
    bus_address_t st_view, ld_view;
    logic         st_mem_hit, st_io_hit, ld_mem_hit, ld_io_hit;
    logic         io_store_done_q, io_load_valid_q;
    bus_word_t    io_rdata_d, io_rdata_q;

    // Reset is released through two flops.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_sync_q <= 1'b0;
            sys_rst_n  <= 1'b0;
        end else begin
            rst_sync_q <= 1'b1;
            sys_rst_n  <= rst_sync_q;
        end
    end

    assign sys_rst_n_o = sys_rst_n;

    // A store colliding with a load waits one cycle.
    assign hold_store = store_req_i & load_req_i & ~wait_store_q;
    assign st_issue   = wait_store_q | (store_req_i & ~load_req_i);
    assign st_addr    = wait_store_q ? held_addr_q : store_addr_i;
    assign st_data    = wait_store_q ? held_data_q : store_data_i;

    assign st_view = st_addr;
    assign ld_view = load_addr_i;

    // Addresses outside both windows complete without effect.
    assign st_mem_hit = (st_addr & ~MEM_END) == MEM_START;
    assign st_io_hit  = (st_addr >= IO_START) && (st_addr <= IO_END);
    assign ld_mem_hit = (load_addr_i & ~MEM_END) == MEM_START;
    assign ld_io_hit  = (load_addr_i >= IO_START) && (load_addr_i <= IO_END);

    assign mem_store_o      = st_issue & st_mem_hit;
    assign mem_store_addr_o = st_addr;
    assign mem_wdata_o      = st_data;
    assign mem_load_o       = load_req_i & ld_mem_hit;
    assign mem_load_addr_o  = load_addr_i;

    assign gpio_wbit_o   = st_data[0];
    assign timer_write_o = st_issue & st_io_hit & st_view.io_view.timer_sel;
    assign timer_waddr_o = st_view.io_view.reg_sel.timer_view.timer_reg;
    assign timer_wdata_o = st_data;
    assign timer_raddr_o = ld_view.io_view.reg_sel.timer_view.timer_reg;

    always_comb begin
        gpio_write_o = '0;
        if (st_issue && st_io_hit && !st_view.io_view.timer_sel
                && !st_view.io_view.input_sel) begin
            gpio_write_o[st_view.io_view.reg_sel.gpio_index] = 1'b1;
        end
    end

    // IO read word, GPIO bits zero-extended.
    always_comb begin
        io_rdata_d = '0;
        if (ld_io_hit) begin
            if (ld_view.io_view.timer_sel) begin
                io_rdata_d = timer_rdata_i;
            end else if (ld_view.io_view.input_sel) begin
                io_rdata_d = bus_word_t'(gpio_in_sync_i[ld_view.io_view.reg_sel.gpio_index]);
            end else begin
                io_rdata_d = bus_word_t'(gpio_out_i[ld_view.io_view.reg_sel.gpio_index]);
            end
        end
    end

    always_ff @(posedge clk_i or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_store_q    <= 1'b0;
            io_store_done_q <= 1'b0;
            io_load_valid_q <= 1'b0;
        end else begin
            wait_store_q    <= hold_store;
            io_store_done_q <= st_issue & ~st_mem_hit;
            io_load_valid_q <= load_req_i & ~ld_mem_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold_store) begin
            held_addr_q <= store_addr_i;  // Deferred store.
            held_data_q <= store_data_i;
        end
        if (load_req_i) begin
            io_rdata_q <= io_rdata_d;
        end
    end

    assign store_done_o = mem_done_i | io_store_done_q;
    assign load_valid_o = mem_valid_i | io_load_valid_q;
    assign load_data_o  = io_load_valid_q ? io_rdata_q : mem_rdata_i;

endmodule

// ==== mmio_timer.sv ====
`timescale 1ns/10ps

module mmio_timer (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            write_i,
    input  logic [1:0]                      write_addr_i,
    input  board_memory_map_pkg::bus_word_t write_data_i,
    input  logic [1:0]                      read_addr_i,
    output board_memory_map_pkg::bus_word_t read_data_o,
    output logic                            timer_level_o
);
    import board_memory_map_pkg::*;
    import board_io_pkg::*;

    bus_word_t count_q;
    bus_word_t compare_q;
    logic      enable_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
        end else begin
            // A write to the count register wins over the increment.
            if (write_i && write_addr_i == TIMER_REG_COUNT) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end

            if (write_i && write_addr_i == TIMER_REG_COMPARE) begin
                compare_q <= write_data_i;
            end

            if (write_i && write_addr_i == TIMER_REG_CONTROL) begin
                enable_q <= write_data_i[TIMER_ENABLE_BIT];
            end
        end
    end

    always_comb begin
        read_data_o = '0;
        case (read_addr_i)
            TIMER_REG_COUNT:   read_data_o = count_q;
            TIMER_REG_COMPARE: read_data_o = compare_q;
            TIMER_REG_CONTROL: read_data_o[TIMER_ENABLE_BIT] = enable_q;
            default:           read_data_o = '0;  // Unused index.
        endcase
    end

    // Level stays high until the count is cleared or the timer is stopped.
    assign timer_level_o = enable_q & (count_q >= compare_q);

endmodule

// ==== src.f ====
board_memory_map_pkg.sv
board_io_pkg.sv
io_bus_controller.sv
gpio_bank.sv
mmio_timer.sv
interrupt_controller.sv
data_memory.sv
board_io_subsystem.sv
tb_board_io_assertions.sv
tb_board_io_subsystem.sv

// ==== tb_board_io_assertions.sv ====
`timescale 1ns/10ps

module tb_board_io_assertions (
    input logic                      clk_i,
    input logic                      sys_rst_n_i,
    input logic                      store_req_i,
    input logic                      store_done_i,
    input logic                      load_req_i,
    input logic                      load_valid_i,
    input logic                      irq_i,
    input logic                      timer_irq_i,
    input board_io_pkg::irq_vector_t irq_vector_i,
    input board_io_pkg::gpio_t       gpio_out_i
);
    import board_io_pkg::*;

    // A store completes one cycle later, or two when it was deferred.
    store_done_after_request: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        store_done_i |-> $past(store_req_i, 1) || $past(store_req_i, 2))
        else $error("store_done_o without a store request one or two cycles before");

    load_valid_follows_request: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        load_req_i |=> load_valid_i)
        else $error("load_valid_o missing one cycle after load_req_i");

    load_valid_needs_request: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        load_valid_i |-> $past(load_req_i))
        else $error("load_valid_o without a load request one cycle before");

    timer_vector_reported: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        timer_irq_i |-> irq_vector_i == TIMER_VECTOR)
        else $error("timer_irq_o set while irq_vector_o is not the timer vector");

    quiet_in_reset: assert property (@(posedge clk_i)
        !sys_rst_n_i |-> !(store_done_i || load_valid_i || irq_i || timer_irq_i)
                         && irq_vector_i == '0 && gpio_out_i == '0)
        else $error("Bus or interrupt output active during internal reset");

endmodule

bind board_io_subsystem tb_board_io_assertions i_board_io_assertions (
    .clk_i        (clk_i),
    .sys_rst_n_i  (sys_rst_n),
    .store_req_i  (store_req_i),
    .store_done_i (store_done_o),
    .load_req_i   (load_req_i),
    .load_valid_i (load_valid_o),
    .irq_i        (irq_o),
    .timer_irq_i  (timer_irq_o),
    .irq_vector_i (irq_vector_o),
    .gpio_out_i   (gpio_o)
);

// ==== tb_board_io_subsystem.sv ====
`timescale 1ns/10ps

module tb_board_io_subsystem;
    import board_memory_map_pkg::*;
    import board_io_pkg::*;

    localparam int WAIT_LIMIT             = 20;  // Cycles allowed for any handshake.
    localparam int STORE_LATENCY          = 1;
    localparam int DEFERRED_STORE_LATENCY = 2;   // Store that met a load in its cycle.
    localparam int LOAD_LATENCY           = 1;

    logic        clk_i;
    logic        rst_n_i;
    gpio_t       gpio_i, gpio_o;
    logic        store_req_i, store_done_o;
    bus_word_t   store_addr_i, store_data_i;
    logic        load_req_i, load_valid_o;
    bus_word_t   load_addr_i, load_data_o;
    logic        irq_ack_i, irq_o, timer_irq_o;
    irq_vector_t irq_vector_o;

    board_io_subsystem i_board_io_subsystem (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .gpio_i       (gpio_i),
        .gpio_o       (gpio_o),
        .store_req_i  (store_req_i),
        .store_addr_i (store_addr_i),
        .store_data_i (store_data_i),
        .store_done_o (store_done_o),
        .load_req_i   (load_req_i),
        .load_addr_i  (load_addr_i),
        .load_data_o  (load_data_o),
        .load_valid_o (load_valid_o),
        .irq_ack_i    (irq_ack_i),
        .irq_o        (irq_o),
        .timer_irq_o  (timer_irq_o),
        .irq_vector_o (irq_vector_o)
    );

    always #4 clk_i = ~clk_i;  // 8 ns period.

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word_at_least(input string name, input bus_word_t got,
                                       input bus_word_t minimum);
        if ($isunknown(got) || got < minimum) begin
            $display("FAIL %s: got %h, expected at least %h", name, got, minimum);
            stop_on_error();
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_vector(input string name, input irq_vector_t got, input irq_vector_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %h cycles, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Outputs are registered, so they are settled 1 ns after the edge.
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Issues a store, a load or both in one cycle and waits for each response.
    task automatic run_access(input logic do_store, input logic do_load, input bus_word_t addr,
                              input bus_word_t data, output bus_word_t loaded);
        int cycles;
        int store_cycles;
        int load_cycles;
        cycles       = 0;
        store_cycles = do_store ? 0 : -1;
        load_cycles  = do_load ? 0 : -1;
        loaded       = '0;
        store_req_i  = do_store;
        store_addr_i = addr;
        store_data_i = data;
        load_req_i   = do_load;
        load_addr_i  = addr;
        while ((store_cycles == 0 || load_cycles == 0) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
            store_req_i = 1'b0;  // Strobes last one cycle.
            load_req_i  = 1'b0;
            if (store_done_o && store_cycles == 0) begin
                store_cycles = cycles;
            end
            if (load_valid_o && load_cycles == 0) begin
                load_cycles = cycles;
                loaded      = load_data_o;
            end
        end
        if (store_cycles == 0 || load_cycles == 0) begin
            $display("Timeout: no response within %0d cycles for address %h", WAIT_LIMIT, addr);
            stop_on_error();
        end
        if (do_store) begin
            check_latency("store_done_o latency", store_cycles,
                          do_load ? DEFERRED_STORE_LATENCY : STORE_LATENCY);
        end
        if (do_load) begin
            check_latency("load_valid_o latency", load_cycles, LOAD_LATENCY);
        end
    endtask

    task automatic wait_for_irq(input logic [1:0] flags, input irq_vector_t vector);
        int cycles;
        cycles = 0;
        while ({timer_irq_o, irq_o} !== flags && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if ({timer_irq_o, irq_o} !== flags) begin
            $display("Timeout: timer_irq_o and irq_o stayed at %b instead of %b",
                     {timer_irq_o, irq_o}, flags);
            stop_on_error();
        end
        check_vector("irq_vector_o", irq_vector_o, vector);
    endtask

    task automatic acknowledge_irq();
        irq_ack_i = 1'b1;
        next_cycle();
        irq_ack_i = 1'b0;
    endtask

    initial begin
        int            fd;
        int            n;
        int            i;
        logic [7:0]    op;
        bus_word_t     addr, data, expected, got;
        logic [1023:0] skipped;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        gpio_i       = '0;
        store_req_i  = 1'b0;
        store_addr_i = '0;
        store_data_i = '0;
        load_req_i   = 1'b0;
        load_addr_i  = '0;
        irq_ack_i    = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        repeat (3) next_cycle();  // Internal reset ends two edges later.

        fd = $fopen("board_io_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file board_io_stim.txt");
            stop_on_error();
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                n = $fgets(skipped, fd);  // Comment line.
            end else begin
                n = $fscanf(fd, "%h %h %h", addr, data, expected);
                if (n != 3) begin
                    $display("Stimulus line for operation %s does not hold three values", op);
                    stop_on_error();
                end
                case (op)
                    "S": run_access(1'b1, 1'b0, addr, data, got);
                    "L": begin
                        run_access(1'b0, 1'b1, addr, data, got);
                        check_word("load_data_o", got, expected);
                    end
                    "B": begin
                        run_access(1'b1, 1'b1, addr, data, got);
                        check_word("load_data_o", got, expected);  // Still the old word.
                    end
                    "K": begin
                        run_access(1'b0, 1'b1, addr, data, got);
                        check_word_at_least("load_data_o", got, expected);
                    end
                    "G": gpio_i = gpio_t'(data);
                    "O": check_gpio("gpio_o", gpio_o, gpio_t'(expected));
                    "V": wait_for_irq(data[1:0], irq_vector_t'(expected));
                    "A": acknowledge_irq();
                    "W": for (i = 0; i < data; i++) next_cycle();
                    default: begin
                        $display("Unknown operation %s in the stimulus file", op);
                        stop_on_error();
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("Test completed successfully");
        $finish;
    end

endmodule
